/* src/biu_pkg.sv */
package biu_pkg;

   localparam int ADDR_W = 20;   // physical address
   localparam int DATA_W = 16;   // core data word
   localparam int BYTE_W = 8;    // external bus

   // bus cycle T-states
   typedef enum logic [2:0] {
      T_IDLE = 3'd0,   // idle
      T1     = 3'd1,   // address
      T2     = 3'd2,   // strobe
      T3     = 3'd3,   // data
      T4     = 3'd4    // release
   } bus_state_e;

   typedef enum logic [1:0] {
      I_IDLE = 2'd0,
      I_WAIT = 2'd1,   // pending, waiting for a boundary
      I_OUT  = 2'd2
   } intr_state_e;

   typedef enum logic {
      H_IDLE  = 1'b0,
      H_GRANT = 1'b1
   } hold_state_e;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic              is_write;
      logic              is_io;
      logic              is_byte;
   } cpu_req_t;

   // 8088 active levels
   typedef struct packed {
      logic ale;
      logic rd_n;
      logic wr_n;
      logic den_n;
      logic dtr;     // high while the 8088 drives data
      logic iom;     // high for i/o
   } bus_ctl_t;

   // all strobes released
   localparam bus_ctl_t BUS_IDLE = '{ale: 1'b0, rd_n: 1'b1, wr_n: 1'b1,
                                     den_n: 1'b1, dtr: 1'b0, iom: 1'b0};

endpackage

/* src/biu_req_stage.sv */
module biu_req_stage (
   input  logic              clk,
   input  logic              rst,
   input  logic              req_i,
   input  biu_pkg::cpu_req_t req_data_i,
   input  logic              hold_block_i,
   input  logic              cpu_inta_i,
   input  logic              done_i,
   output logic              go_o,
   output biu_pkg::cpu_req_t cur_req_o,
   output logic              busy_o
);

   logic accept;
   logic busy_q;
   logic go_q;
   biu_pkg::cpu_req_t req_q;

   // the only place a request gets taken
   assign accept = req_i & ~busy_q & ~hold_block_i & ~cpu_inta_i;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         busy_q <= 1'b0;
         go_q   <= 1'b0;
      end else begin
         go_q <= accept;    // one cycle start pulse
         if (accept)
            busy_q <= 1'b1;
         else if (done_i)
            busy_q <= 1'b0;
      end
   end

   // request payload, held until done
   always_ff @(posedge clk) begin
      if (accept)
         req_q <= req_data_i;
   end

   assign go_o      = go_q;
   assign cur_req_o = req_q;
   assign busy_o    = busy_q;   // stalls the core

endmodule

/* src/biu_bus_seq.sv */
module biu_bus_seq (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        go_i,
   input  biu_pkg::cpu_req_t           cur_req_i,
   input  logic                        ready_i,
   output biu_pkg::bus_ctl_t           bus_o,
   output logic [biu_pkg::ADDR_W-1:0]  a_o,
   output logic [biu_pkg::BYTE_W-1:0]  ad_o,
   output logic                        ad_oe_o,
   output logic                        cap_o,
   output logic                        cap_idx_o,
   output logic                        last_o
);

   biu_pkg::bus_state_e state, state_nxt;
   logic idx;          // 0 low byte, 1 high byte
   logic final_byte;
   logic active;
   logic [biu_pkg::BYTE_W-1:0] wr_byte;

   assign final_byte = cur_req_i.is_byte | idx;
   assign active     = (state != biu_pkg::T_IDLE);

   // second byte lives at addr + 1
   assign a_o = cur_req_i.addr + {{(biu_pkg::ADDR_W-1){1'b0}}, idx};
   assign wr_byte = idx ? cur_req_i.wdata[2*biu_pkg::BYTE_W-1:biu_pkg::BYTE_W]
                        : cur_req_i.wdata[biu_pkg::BYTE_W-1:0];

   always_comb begin
      state_nxt = state;
      case (state)
         biu_pkg::T_IDLE: if (go_i) state_nxt = biu_pkg::T1;
         biu_pkg::T1:     state_nxt = biu_pkg::T2;
         biu_pkg::T2:     state_nxt = biu_pkg::T3;
         biu_pkg::T3:     if (ready_i) state_nxt = biu_pkg::T4;   // wait states
         biu_pkg::T4:     state_nxt = final_byte ? biu_pkg::T_IDLE : biu_pkg::T1;
         default:         state_nxt = biu_pkg::T_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state <= biu_pkg::T_IDLE;
         idx   <= 1'b0;
      end else begin
         state <= state_nxt;
         if (state == biu_pkg::T_IDLE)
            idx <= 1'b0;
         else if (state == biu_pkg::T4 && !final_byte)
            idx <= 1'b1;   // on to the high byte
      end
   end

   // strobes and ad bus from the T-state
   always_comb begin
      bus_o   = biu_pkg::BUS_IDLE;
      ad_o    = a_o[biu_pkg::BYTE_W-1:0];
      ad_oe_o = 1'b0;
      if (active) begin
         bus_o.dtr = cur_req_i.is_write;
         bus_o.iom = cur_req_i.is_io;
      end
      case (state)
         biu_pkg::T1: begin
            bus_o.ale = 1'b1;
            ad_oe_o   = 1'b1;   // address low byte
         end
         biu_pkg::T2, biu_pkg::T3: begin
            bus_o.den_n = 1'b0;
            if (cur_req_i.is_write) begin
               bus_o.wr_n = 1'b0;
               ad_o       = wr_byte;
               ad_oe_o    = 1'b1;
            end else begin
               bus_o.rd_n = 1'b0;   // ad turned around
            end
         end
         biu_pkg::T4: begin
            // data held while wr_n rises
            if (cur_req_i.is_write) begin
               ad_o    = wr_byte;
               ad_oe_o = 1'b1;
            end
         end
         default: ;
      endcase
   end

   assign cap_o     = (state == biu_pkg::T3) & ready_i & ~cur_req_i.is_write;
   assign cap_idx_o = idx;
   assign last_o    = (state == biu_pkg::T4) & final_byte;

endmodule

/* src/biu_rd_assemble.sv */
module biu_rd_assemble (
   input  logic                        clk,
   input  logic                        rst,
   input  logic [biu_pkg::BYTE_W-1:0]  ad_i,
   input  logic                        cap_i,
   input  logic                        cap_idx_i,
   input  logic                        last_i,
   input  logic                        is_byte_i,
   input  logic                        cpu_inta_i,
   input  logic [biu_pkg::BYTE_W-1:0]  iid_i,
   output logic [biu_pkg::DATA_W-1:0]  rd_data_o,
   output logic                        done_o
);

   logic [biu_pkg::BYTE_W-1:0] lo_q, hi_q;
   logic [biu_pkg::BYTE_W-1:0] hi_word;
   logic [biu_pkg::DATA_W-1:0] rd_q;
   logic rd_seen;   // set once a byte came in, so writes leave rd_q alone
   logic done_q;

   always_ff @(posedge clk) begin
      if (cap_i && !cap_idx_i)
         lo_q <= ad_i;
      if (cap_i && cap_idx_i)
         hi_q <= ad_i;
   end

   // byte read: sign extend from bit 7
   assign hi_word = is_byte_i ? {biu_pkg::BYTE_W{lo_q[biu_pkg::BYTE_W-1]}} : hi_q;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         rd_q    <= '0;
         rd_seen <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         done_q <= last_i;
         if (last_i) begin
            rd_seen <= 1'b0;
            if (rd_seen)
               rd_q <= {hi_word, lo_q};
         end else if (cap_i) begin
            rd_seen <= 1'b1;
         end
      end
   end

   // vector replaces bus data during acknowledge
   assign rd_data_o = cpu_inta_i ? {{biu_pkg::BYTE_W{1'b0}}, iid_i} : rd_q;
   assign done_o    = done_q;

endmodule

/* src/biu_intr_gate.sv */
module biu_intr_gate (
   input  logic clk,
   input  logic rst,
   input  logic intr_i,
   input  logic boundary_i,
   input  logic cpu_inta_i,
   output logic cpu_intr_o,
   output logic inta_n_o
);

   biu_pkg::intr_state_e state, state_nxt;

   always_comb begin
      state_nxt = state;
      case (state)
         biu_pkg::I_IDLE: begin
            if (intr_i)
               state_nxt = boundary_i ? biu_pkg::I_OUT : biu_pkg::I_WAIT;
         end
         biu_pkg::I_WAIT: begin
            if (!intr_i)
               state_nxt = biu_pkg::I_IDLE;   // request withdrawn
            else if (boundary_i)
               state_nxt = biu_pkg::I_OUT;
         end
         biu_pkg::I_OUT: begin
            if (!intr_i)
               state_nxt = biu_pkg::I_IDLE;
         end
         default: state_nxt = biu_pkg::I_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst)
         state <= biu_pkg::I_IDLE;
      else
         state <= state_nxt;
   end

   // never mid-instruction
   assign cpu_intr_o = (state == biu_pkg::I_OUT);
   assign inta_n_o   = ~cpu_inta_i;

endmodule

/* src/biu_hold_ctrl.sv */
module biu_hold_ctrl (
   input  logic clk,
   input  logic rst,
   input  logic hold_i,
   input  logic busy_i,
   output logic hlda_o,
   output logic hold_block_o
);

   biu_pkg::hold_state_e state, state_nxt;

   always_comb begin
      state_nxt = state;
      case (state)
         biu_pkg::H_IDLE: begin
            // only between transfers
            if (hold_i && !busy_i)
               state_nxt = biu_pkg::H_GRANT;
         end
         biu_pkg::H_GRANT: begin
            if (!hold_i)
               state_nxt = biu_pkg::H_IDLE;
         end
         default: state_nxt = biu_pkg::H_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst)
         state <= biu_pkg::H_IDLE;
      else
         state <= state_nxt;
   end

   assign hlda_o = (state == biu_pkg::H_GRANT);
   assign hold_block_o = hold_i | hlda_o;   // pending or granted

endmodule

/* src/bus_8088_top.sv */
module bus_8088_top (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        req_i,
   input  biu_pkg::cpu_req_t           req_data_i,
   input  logic                        ready_i,
   input  logic [biu_pkg::BYTE_W-1:0]  ad_i,
   input  logic                        hold_i,
   input  logic                        intr_i,
   input  logic                        boundary_i,
   input  logic                        cpu_inta_i,
   input  logic [biu_pkg::BYTE_W-1:0]  iid_i,
   output logic                        busy_o,
   output logic                        done_o,
   output logic [biu_pkg::DATA_W-1:0]  rd_data_o,
   output logic [biu_pkg::ADDR_W-1:0]  a_o,
   output logic [biu_pkg::BYTE_W-1:0]  ad_o,
   output logic                        ad_oe_o,
   output biu_pkg::bus_ctl_t           bus_o,
   output logic                        hlda_o,
   output logic                        cpu_intr_o,
   output logic                        inta_n_o
);

   biu_pkg::cpu_req_t cur_req;
   biu_pkg::bus_ctl_t seq_bus;
   logic go, hold_block, seq_oe;
   logic cap, cap_idx, last;

   biu_req_stage u_req (
      .clk(clk), .rst(rst), .req_i(req_i), .req_data_i(req_data_i),
      .hold_block_i(hold_block), .cpu_inta_i(cpu_inta_i), .done_i(done_o),
      .go_o(go), .cur_req_o(cur_req), .busy_o(busy_o));

   biu_bus_seq u_seq (
      .clk(clk), .rst(rst), .go_i(go), .cur_req_i(cur_req), .ready_i(ready_i),
      .bus_o(seq_bus), .a_o(a_o), .ad_o(ad_o), .ad_oe_o(seq_oe),
      .cap_o(cap), .cap_idx_o(cap_idx), .last_o(last));

   biu_rd_assemble u_rd (
      .clk(clk), .rst(rst), .ad_i(ad_i), .cap_i(cap), .cap_idx_i(cap_idx),
      .last_i(last), .is_byte_i(cur_req.is_byte), .cpu_inta_i(cpu_inta_i),
      .iid_i(iid_i), .rd_data_o(rd_data_o), .done_o(done_o));

   biu_intr_gate u_intr (
      .clk(clk), .rst(rst), .intr_i(intr_i), .boundary_i(boundary_i),
      .cpu_inta_i(cpu_inta_i), .cpu_intr_o(cpu_intr_o), .inta_n_o(inta_n_o));

   biu_hold_ctrl u_hold (
      .clk(clk), .rst(rst), .hold_i(hold_i), .busy_i(busy_o),
      .hlda_o(hlda_o), .hold_block_o(hold_block));

   // bus released to the hold master
   assign bus_o   = hlda_o ? biu_pkg::BUS_IDLE : seq_bus;
   assign ad_oe_o = seq_oe & ~hlda_o;

endmodule

/* verif/bus_8088_checker.sv */
module bus_8088_checker (
   input logic              clk,
   input logic              rst,
   input biu_pkg::bus_ctl_t bus_o,
   input logic              ad_oe_o,
   input logic              hlda_o,
   input logic              done_o
);
   timeunit 1ns;
   timeprecision 1ps;

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst) bus_o.rd_n || bus_o.wr_n)
      else $error("rd_n and wr_n low together");

   // address phase only, strobes idle
   a_ale_idle: assert property (@(posedge clk) disable iff (!rst)
      bus_o.ale |-> (bus_o.rd_n && bus_o.wr_n))
      else $error("ale high during a strobe");

   a_hold_float: assert property (@(posedge clk) disable iff (!rst) hlda_o |-> !ad_oe_o)
      else $error("ad bus driven while hold is granted");

   a_done_pulse: assert property (@(posedge clk) disable iff (!rst) done_o |=> !done_o)
      else $error("done_o longer than one cycle");

endmodule

/* verif/bus_8088_tb.sv */
module bus_8088_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int PERIOD    = 100;
   localparam int N_TESTS   = 5;
   localparam int WORST_CYC = 200;   // per test, waits and hold included

   logic clk = 1'b0;
   logic rst, req_i, ready_i, hold_i, intr_i, boundary_i, cpu_inta_i;
   biu_pkg::cpu_req_t req_data_i;
   logic [biu_pkg::BYTE_W-1:0] ad_i = '0;
   logic [biu_pkg::BYTE_W-1:0] ad_o, iid_i;
   logic [biu_pkg::ADDR_W-1:0] a_o;
   logic [biu_pkg::DATA_W-1:0] rd_data_o;
   logic busy_o, done_o, ad_oe_o, hlda_o, cpu_intr_o, inta_n_o;
   biu_pkg::bus_ctl_t bus_o;

   logic [7:0] mem [logic [19:0]];   // sparse byte memory
   logic [19:0] lat_addr = '0;
   logic wr_n_q = 1'b1;
   int ale_cnt = 0;
   int iom_cnt = 0;
   int dtr_cnt = 0;
   int errors = 0;
   int checks = 0;

   bus_8088_top u_dut (.*);

   bind bus_8088_top bus_8088_checker u_chk (.clk(clk), .rst(rst), .bus_o(bus_o),
      .ad_oe_o(ad_oe_o), .hlda_o(hlda_o), .done_o(done_o));

   always #(PERIOD/2) clk = ~clk;

   // untouched locations return a pattern of the whole address
   function automatic logic [7:0] mem_rd(input logic [19:0] a);
      return mem.exists(a) ? mem[a] : (a[7:0] ^ a[15:8] ^ {a[19:16], a[19:16]});
   endfunction

   // bus side memory model
   always @(negedge clk) begin
      wr_n_q <= bus_o.wr_n;
      if (bus_o.ale) begin
         lat_addr <= a_o;
         ale_cnt  <= ale_cnt + 1;
         iom_cnt  <= iom_cnt + int'(bus_o.iom);
         dtr_cnt  <= dtr_cnt + int'(bus_o.dtr);
      end
      if (!wr_n_q && bus_o.wr_n)
         mem[lat_addr] = ad_o;   // wr_n rising
      ad_i <= bus_o.rd_n ? 8'h00 : mem_rd(lat_addr);
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      end
   endtask

   function automatic biu_pkg::cpu_req_t make_req(input logic [19:0] a, input logic [15:0] d,
                                                   input logic wr, input logic io,
                                                   input logic by);
      biu_pkg::cpu_req_t r;
      r = '{addr: a, wdata: d, is_write: wr, is_io: io, is_byte: by};
      return r;
   endfunction

   // one request up to done, ready low for the first waits T3 cycles
   task automatic run_req(input biu_pkg::cpu_req_t r, input int waits, input int hold_at,
                          output logic [15:0] data, output int cycles);
      cycles     = 0;
      req_data_i = r;
      req_i      = 1'b1;
      ready_i    = (waits == 0);
      do begin
         @(posedge clk);
         cycles++;
         if (waits > 0 && cycles == waits + 4) begin
            #1;
            ready_i = 1'b1;
         end
         if (cycles == hold_at) begin
            #1;
            hold_i = 1'b1;   // hold arrives mid transfer
         end
         @(negedge clk);
         if (hold_at > 0)
            check("hlda_o", 32'(hlda_o), 32'h0);
      end while (!done_o && cycles < WORST_CYC);
      if (!done_o) begin
         errors++;
         $display("request to address %h never returned done", r.addr);
      end
      data = rd_data_o;
      @(posedge clk);
      #1;
      req_i = 1'b0;
   endtask

   // request held high, nothing may start
   task automatic expect_blocked(input int n);
      int ale0;
      ale0 = ale_cnt;
      repeat (n) begin
         @(negedge clk);
         check("busy_o", 32'(busy_o), 32'h0);
         check("done_o", 32'(done_o), 32'h0);
      end
      check("ale count", 32'(ale_cnt - ale0), 32'h0);
      @(posedge clk);
      #1;
   endtask

   task automatic word_write_read();
      logic [19:0] addr;
      logic [15:0] wd, rd;
      int cyc;
      int a0;
      int i0;
      int d0;
      addr = 20'($urandom);
      wd   = 16'($urandom);
      a0   = ale_cnt;
      i0   = iom_cnt;
      d0   = dtr_cnt;
      run_req(make_req(addr, wd, 1'b1, 1'b0, 1'b0), 0, 0, rd, cyc);
      check("word write latency", 32'(cyc), 32'd10);
      check("mem[addr]", 32'(mem_rd(addr)), 32'(wd[7:0]));
      check("mem[addr+1]", 32'(mem_rd(addr + 20'd1)), 32'(wd[15:8]));
      run_req(make_req(addr, 16'h0, 1'b0, 1'b0, 1'b0), 0, 0, rd, cyc);
      check("rd_data_o", 32'(rd), 32'(wd));
      check("word read latency", 32'(cyc), 32'd10);
      check("ale count", 32'(ale_cnt - a0), 32'd4);
      check("iom count", 32'(iom_cnt - i0), 32'd0);
      check("dtr count", 32'(dtr_cnt - d0), 32'd2);   // write cycles only
   endtask

   task automatic byte_io_access();
      logic [19:0] addr;
      logic [7:0] d;
      logic [15:0] rd;
      int cyc;
      int i0;
      for (int k = 0; k < 2; k++) begin
         addr = 20'($urandom);
         d    = (k == 0) ? (8'($urandom) | 8'h80) : (8'($urandom) & 8'h7f);
         i0   = iom_cnt;
         run_req(make_req(addr, {8'h00, d}, 1'b1, k == 0, 1'b1), 0, 0, rd, cyc);
         check("byte write latency", 32'(cyc), 32'd6);
         run_req(make_req(addr, 16'h0, 1'b0, k == 0, 1'b1), 0, 0, rd, cyc);
         check("rd_data_o", 32'(rd), 32'({{8{d[7]}}, d}));   // sign extended
         check("iom count", 32'(iom_cnt - i0), (k == 0) ? 32'd2 : 32'd0);
      end
   endtask

   task automatic wait_state_read();
      logic [19:0] addr;
      logic [15:0] wd, rd;
      int cyc;
      int n;
      addr = 20'($urandom);
      wd   = 16'($urandom);
      n    = 1 + int'($urandom % 32'd6);
      run_req(make_req(addr, wd, 1'b1, 1'b0, 1'b0), 0, 0, rd, cyc);
      run_req(make_req(addr, 16'h0, 1'b0, 1'b0, 1'b0), n, 0, rd, cyc);
      check("rd_data_o", 32'(rd), 32'(wd));
      check("wait read latency", 32'(cyc), 32'(10 + n));
   endtask

   task automatic interrupt_ack();
      logic [7:0] vec;
      vec    = 8'($urandom);
      intr_i = 1'b1;
      repeat (4) begin
         @(negedge clk);
         check("cpu_intr_o", 32'(cpu_intr_o), 32'h0);   // no boundary yet
      end
      @(posedge clk);
      #1;
      boundary_i = 1'b1;
      @(posedge clk);
      #1;
      boundary_i = 1'b0;
      @(negedge clk);
      check("cpu_intr_o", 32'(cpu_intr_o), 32'h1);
      @(posedge clk);
      #1;
      cpu_inta_i = 1'b1;
      iid_i      = vec;
      req_data_i = make_req(20'($urandom), 16'h0, 1'b0, 1'b0, 1'b0);
      req_i      = 1'b1;
      @(negedge clk);
      check("inta_n_o", 32'(inta_n_o), 32'h0);
      check("rd_data_o", 32'(rd_data_o), 32'({8'h00, vec}));
      expect_blocked(8);
      req_i      = 1'b0;
      cpu_inta_i = 1'b0;
      intr_i     = 1'b0;
      @(negedge clk);
      check("inta_n_o", 32'(inta_n_o), 32'h1);
      @(negedge clk);
      check("cpu_intr_o", 32'(cpu_intr_o), 32'h0);   // gate left I_OUT at the edge
      @(posedge clk);
      #1;
   endtask

   task automatic hold_handover();
      logic [19:0] addr;
      logic [15:0] wd, rd;
      biu_pkg::cpu_req_t wr_req;
      int cyc;
      addr = 20'($urandom);
      wd   = 16'($urandom);
      run_req(make_req(addr, wd, 1'b1, 1'b0, 1'b0), 0, 0, rd, cyc);
      run_req(make_req(addr, 16'h0, 1'b0, 1'b0, 1'b0), 0, 3, rd, cyc);
      check("rd_data_o", 32'(rd), 32'(wd));
      for (int k = 0; k < 4 && !hlda_o; k++)
         @(negedge clk);
      check("hlda_o", 32'(hlda_o), 32'h1);
      @(posedge clk);
      #1;
      addr       = 20'($urandom);
      wd         = 16'($urandom);
      wr_req     = make_req(addr, wd, 1'b1, 1'b0, 1'b0);
      req_data_i = wr_req;
      req_i      = 1'b1;
      expect_blocked(6);
      hold_i = 1'b0;
      run_req(wr_req, 0, 0, rd, cyc);
      run_req(make_req(addr, 16'h0, 1'b0, 1'b0, 1'b0), 0, 0, rd, cyc);
      check("rd_data_o", 32'(rd), 32'(wd));
   endtask

   initial begin
      void'($urandom(32'h69ab));
      rst        = 1'b0;
      req_i      = 1'b0;
      req_data_i = '0;
      ready_i    = 1'b1;
      hold_i     = 1'b0;
      intr_i     = 1'b0;
      boundary_i = 1'b0;
      cpu_inta_i = 1'b0;
      iid_i      = '0;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b1;
      @(negedge clk);
      check("ale rd_n wr_n den_n", 32'({bus_o.ale, bus_o.rd_n, bus_o.wr_n, bus_o.den_n}), 32'h7);
      check("ad_oe_o", 32'(ad_oe_o), 32'h0);
      check("inta_n_o", 32'(inta_n_o), 32'h1);
      check("busy done hlda intr", 32'({busy_o, done_o, hlda_o, cpu_intr_o}), 32'h0);
      @(posedge clk);
      #1;
      word_write_read();
      byte_io_access();
      wait_state_read();
      interrupt_ack();
      hold_handover();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

   // watchdog
   initial begin
      #(N_TESTS * WORST_CYC * PERIOD);
      $display("watchdog expired before all tests finished");
      $display("TEST FAILED");
      $finish;
   end

endmodule

/* bus_8088.f */
src/biu_pkg.sv
src/biu_req_stage.sv
src/biu_bus_seq.sv
src/biu_rd_assemble.sv
src/biu_intr_gate.sv
src/biu_hold_ctrl.sv
src/bus_8088_top.sv
verif/bus_8088_checker.sv
verif/bus_8088_tb.sv

/* Makefile */
TOP       ?= bus_8088_tb
FILELIST  ?= bus_8088.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
